// ==== common/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address width, shared by both ports and the memory bus
`define MEM_ADDR_BITS 16

// data word width
`define MEM_WORD_BITS 32

// words held by the memory controller
// word index is taken from address bits 9 down to 2
`define MEM_DEPTH_WORDS 256

// clock edges from an accepted request to its completion pulse
// must be 1 or more
`define MEM_LATENCY 3

`endif

// ==== common/mem_pkg.sv ====
`include "mem_defs.svh"

package mem_pkg;

  // byte address as seen by the ports and the memory bus
  typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;

  // one data word
  typedef logic [`MEM_WORD_BITS-1:0] mem_word_t;

  // which port currently owns the memory
  typedef enum logic [1:0] {
    FREE  = 2'd0,
    INSTR = 2'd1,
    DATA  = 2'd2
  } mmu_lock_e;

endpackage

// ==== files.f ====
+incdir+common
common/mem_pkg.sv
hdl/memory_management_unit.sv
memory/memory_controller.sv
hdl/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

// ==== hdl/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic              clock,
  input  logic              arst_n,

  // instruction fetch port
  input  logic              instr_read,
  input  mem_pkg::mem_addr_t instr_address,
  output mem_pkg::mem_word_t instr_rdata,
  output logic              instr_ready,

  // data port
  input  logic              data_read,
  input  logic              data_write,
  input  mem_pkg::mem_addr_t data_address,
  input  mem_pkg::mem_word_t data_wdata,
  output mem_pkg::mem_word_t data_rdata,
  output logic              data_ready,
  output logic              data_done
);

  import mem_pkg::*;

  // shared memory bus between the unit and the controller
  logic      mem_read;
  logic      mem_write;
  mem_addr_t mem_address;
  mem_word_t mem_wdata;
  mem_word_t mem_rdata;
  logic      mem_ready;
  logic      mem_done;

  memory_management_unit u_mmu (
    .clock         (clock),
    .arst_n        (arst_n),
    .instr_read    (instr_read),
    .instr_address (instr_address),
    .instr_rdata   (instr_rdata),
    .instr_ready   (instr_ready),
    .data_read     (data_read),
    .data_write    (data_write),
    .data_address  (data_address),
    .data_wdata    (data_wdata),
    .data_rdata    (data_rdata),
    .data_ready    (data_ready),
    .data_done     (data_done),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .mem_address   (mem_address),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .mem_ready     (mem_ready),
    .mem_done      (mem_done)
  );

  memory_controller u_memory (
    .clock       (clock),
    .arst_n      (arst_n),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_address (mem_address),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_ready   (mem_ready),
    .mem_done    (mem_done)
  );

endmodule

// ==== hdl/memory_management_unit.sv ====
`timescale 1ns/1ps

module memory_management_unit (
  input  logic              clock,
  input  logic              arst_n,

  // instruction fetch port
  input  logic              instr_read,
  input  mem_pkg::mem_addr_t instr_address,
  output mem_pkg::mem_word_t instr_rdata,
  output logic              instr_ready,

  // data port
  input  logic              data_read,
  input  logic              data_write,
  input  mem_pkg::mem_addr_t data_address,
  input  mem_pkg::mem_word_t data_wdata,
  output mem_pkg::mem_word_t data_rdata,
  output logic              data_ready,
  output logic              data_done,

  // memory bus towards the controller
  output logic              mem_read,
  output logic              mem_write,
  output mem_pkg::mem_addr_t mem_address,
  output mem_pkg::mem_word_t mem_wdata,
  input  mem_pkg::mem_word_t mem_rdata,
  input  logic              mem_ready,
  input  logic              mem_done
);

  import mem_pkg::*;

  // current owner, registered
  mmu_lock_e lock_q;
  mmu_lock_e lock_d;

  // owner for this cycle, either the held lock or a fresh pick
  mmu_lock_e grant;

  // completion of whatever access is in flight
  logic      complete;

  assign complete = mem_ready | mem_done;

  // pick an owner only while the memory is free
  // instruction fetch wins a tie with the data port
  always_comb begin
    grant = lock_q;
    if (lock_q == FREE) begin
      if (instr_read) begin
        grant = INSTR;
      end else if (data_read || data_write) begin
        grant = DATA;
      end else begin
        grant = FREE;
      end
    end
  end

  // hold the owner until its pulse, then release
  // a pending write is never cut off by a fetch
  always_comb begin
    if (complete) begin
      lock_d = FREE;
    end else begin
      lock_d = grant;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      lock_q <= FREE;
    end else begin
      lock_q <= lock_d;
    end
  end

  // steer the granted port onto the memory bus
  always_comb begin
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    mem_address = '0;
    mem_wdata   = '0;
    case (grant)
      INSTR: begin
        mem_read    = instr_read;
        mem_address = instr_address;
      end
      DATA: begin
        mem_read    = data_read;
        mem_write   = data_write;
        mem_address = data_address;
        mem_wdata   = data_wdata;
      end
      default: begin
        // nobody granted, bus stays quiet
        mem_read    = 1'b0;
        mem_write   = 1'b0;
      end
    endcase
  end

  // responses only reach the port that holds the lock
  // the pulse arrives while lock_q still names the owner
  always_comb begin
    instr_rdata = '0;
    instr_ready = 1'b0;
    data_rdata  = '0;
    data_ready  = 1'b0;
    data_done   = 1'b0;
    case (lock_q)
      INSTR: begin
        instr_rdata = mem_rdata;
        instr_ready = mem_ready;
      end
      DATA: begin
        data_rdata = mem_rdata;
        data_ready = mem_ready;
        data_done  = mem_done;
      end
      default: begin
        instr_ready = 1'b0;
        data_ready  = 1'b0;
        data_done   = 1'b0;
      end
    endcase
  end

endmodule

// ==== memory/memory_controller.sv ====
`timescale 1ns/1ps

`include "mem_defs.svh"

module memory_controller (
  input  logic              clock,
  input  logic              arst_n,

  input  logic              mem_read,
  input  logic              mem_write,
  input  mem_pkg::mem_addr_t mem_address,
  input  mem_pkg::mem_word_t mem_wdata,
  output mem_pkg::mem_word_t mem_rdata,
  output logic              mem_ready,
  output logic              mem_done
);

  import mem_pkg::*;

  // word index comes from the bits just above the byte offset
  localparam int INDEX_BITS = $clog2(`MEM_DEPTH_WORDS);

  // counter runs from latency-1 down to zero
  localparam int COUNT_BITS = ($clog2(`MEM_LATENCY) > 0) ? $clog2(`MEM_LATENCY) : 1;

  // storage, contents undefined until written
  mem_word_t storage_q [`MEM_DEPTH_WORDS];

  // access in flight
  logic                  busy_q;
  logic [COUNT_BITS-1:0] count_q;
  logic                  write_q;
  logic [INDEX_BITS-1:0] index_q;
  mem_word_t             wdata_q;

  // registered completion pulses and read data
  logic                  ready_q;
  logic                  done_q;
  mem_word_t             rdata_q;

  logic                  idle;
  logic                  accept;
  logic                  finish;

  // the pulse cycle still counts as busy, so a level that is
  // held through the pulse is not taken a second time
  assign idle   = !busy_q && !ready_q && !done_q;
  assign accept = idle && (mem_read || mem_write);
  assign finish = busy_q && (count_q == '0);

  // control path
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q  <= 1'b0;
      count_q <= '0;
      ready_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      ready_q <= finish && !write_q;
      done_q  <= finish && write_q;
      if (accept) begin
        busy_q  <= 1'b1;
        count_q <= COUNT_BITS'(`MEM_LATENCY - 1);
      end else if (finish) begin
        busy_q  <= 1'b0;
      end else if (busy_q) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // operation captured on the accepting edge
  always_ff @(posedge clock) begin
    if (accept) begin
      write_q <= mem_write;
      index_q <= mem_address[2 +: INDEX_BITS];
      wdata_q <= mem_wdata;
    end
  end

  // storage is read and written on the edge that raises the pulse
  always_ff @(posedge clock) begin
    if (finish) begin
      if (write_q) begin
        storage_q[index_q] <= wdata_q;
      end else begin
        rdata_q <= storage_q[index_q];
      end
    end
  end

  assign mem_rdata = rdata_q;
  assign mem_ready = ready_q;
  assign mem_done  = done_q;

endmodule

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

`include "mem_defs.svh"

module tb_mem_subsystem;

  import mem_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int RESET_CYCLES   = 8;

  typedef enum int {
    KIND_IREAD,
    KIND_DREAD,
    KIND_DWRITE,
    KIND_PAIR
  } kind_e;

  typedef enum int {
    PORT_INSTR,
    PORT_DREAD,
    PORT_DWRITE
  } port_e;

  typedef struct {
    kind_e     kind;
    mem_addr_t iaddr;
    mem_addr_t daddr;
    mem_word_t wdata;
    mem_word_t expected;
    logic      use_model;
  } entry_t;

  logic      clock;
  logic      arst_n;
  logic      instr_read;
  mem_addr_t instr_address;
  mem_word_t instr_rdata;
  logic      instr_ready;
  logic      data_read;
  logic      data_write;
  mem_addr_t data_address;
  mem_word_t data_wdata;
  mem_word_t data_rdata;
  logic      data_ready;
  logic      data_done;

  entry_t      stim [$];
  mem_word_t   model_mem [`MEM_DEPTH_WORDS];
  logic [15:0] lfsr_state;
  int          error_count;

  mem_subsystem_top i_mem_subsystem_top (
    .clock         (clock),
    .arst_n        (arst_n),
    .instr_read    (instr_read),
    .instr_address (instr_address),
    .instr_rdata   (instr_rdata),
    .instr_ready   (instr_ready),
    .data_read     (data_read),
    .data_write    (data_write),
    .data_address  (data_address),
    .data_wdata    (data_wdata),
    .data_rdata    (data_rdata),
    .data_ready    (data_ready),
    .data_done     (data_done)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  // one lfsr step per bit of the word
  task automatic random_word(output mem_word_t word);
    int b;
    for (b = 0; b < 32; b++) begin
      word[b]    = lfsr_state[15];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // word index is byte address bits 9 down to 2
  function automatic int word_index(input mem_addr_t addr);
    return int'(addr[9:2]);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at time %0t: %s actual %h expected %h", $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopping on first error");
    end
  endtask

  task automatic report_timeout(input string port);
    error_count++;
    $display("no completion pulse on %s port within %0d cycles", port, TIMEOUT_CYCLES);
    $display("Test failures found");
    $fatal(1, "stopping on timeout");
  endtask

  task automatic add_entry(input kind_e kind, input mem_addr_t iaddr, input mem_addr_t daddr,
                           input mem_word_t expected, input logic use_model);
    entry_t e;
    e.kind      = kind;
    e.iaddr     = iaddr;
    e.daddr     = daddr;
    e.expected  = expected;
    e.use_model = use_model;
    e.wdata     = '0;
    if (kind == KIND_DWRITE) begin
      random_word(e.wdata);
    end
    stim.push_back(e);
  endtask

  task automatic build_stimulus();
    mem_word_t wrap_word;
    mem_word_t offset_word;
    add_entry(KIND_DWRITE, '0, 16'h0010, '0, 1'b1);
    add_entry(KIND_DWRITE, '0, 16'h0024, '0, 1'b1);
    add_entry(KIND_DWRITE, '0, 16'h03fc, '0, 1'b1);
    add_entry(KIND_DREAD, '0, 16'h0010, '0, 1'b1);
    add_entry(KIND_IREAD, 16'h0024, '0, '0, 1'b1);
    add_entry(KIND_PAIR, 16'h0010, 16'h0024, '0, 1'b1);
    // 0x0448 and 0x0048 and 0xfc48 share word 0x12
    add_entry(KIND_DWRITE, '0, 16'h0448, '0, 1'b1);
    wrap_word = stim[stim.size()-1].wdata;
    add_entry(KIND_DREAD, '0, 16'h0048, wrap_word, 1'b0);
    add_entry(KIND_IREAD, 16'hfc48, '0, wrap_word, 1'b0);
    // byte offset bits do not select a different word
    add_entry(KIND_DWRITE, '0, 16'h0033, '0, 1'b1);
    offset_word = stim[stim.size()-1].wdata;
    add_entry(KIND_DREAD, '0, 16'h0030, offset_word, 1'b0);
    add_entry(KIND_IREAD, 16'h0031, '0, '0, 1'b1);
    add_entry(KIND_PAIR, 16'h03fc, 16'h0448, '0, 1'b1);
    add_entry(KIND_DWRITE, '0, 16'h0010, '0, 1'b1);
    add_entry(KIND_DREAD, '0, 16'h0010, '0, 1'b1);
    add_entry(KIND_IREAD, 16'h0410, '0, '0, 1'b1);
  endtask

  task automatic check_pulses_low();
    check_value("instr_ready", instr_ready, 1'b0);
    check_value("data_ready", data_ready, 1'b0);
    check_value("data_done", data_done, 1'b0);
  endtask

  // edges counts rising edges and the first one samples the request
  task automatic wait_pulse(input port_e port, output int edges);
    logic seen;
    seen  = 1'b0;
    edges = 0;
    while (!seen && edges < TIMEOUT_CYCLES) begin
      @(posedge clock);
      edges++;
      @(negedge clock);
      case (port)
        PORT_INSTR: begin
          check_value("data_ready", data_ready, 1'b0);
          check_value("data_done", data_done, 1'b0);
          seen = instr_ready;
        end
        PORT_DREAD: begin
          check_value("instr_ready", instr_ready, 1'b0);
          check_value("data_done", data_done, 1'b0);
          seen = data_ready;
        end
        default: begin
          check_value("instr_ready", instr_ready, 1'b0);
          check_value("data_ready", data_ready, 1'b0);
          seen = data_done;
        end
      endcase
    end
    if (!seen) begin
      report_timeout(port == PORT_INSTR ? "instr" : "data");
    end
  endtask

  task automatic apply_entry(input entry_t e);
    int        edges;
    mem_word_t exp_instr;
    mem_word_t exp_data;
    exp_instr = e.use_model ? model_mem[word_index(e.iaddr)] : e.expected;
    exp_data  = e.use_model ? model_mem[word_index(e.daddr)] : e.expected;
    instr_address = e.iaddr;
    data_address  = e.daddr;
    data_wdata    = e.wdata;
    instr_read    = (e.kind == KIND_IREAD) || (e.kind == KIND_PAIR);
    data_read     = (e.kind == KIND_DREAD) || (e.kind == KIND_PAIR);
    data_write    = (e.kind == KIND_DWRITE);

    if (instr_read) begin
      // the instruction side wins any tie and so never waits
      wait_pulse(PORT_INSTR, edges);
      check_value("instr_latency", edges - 1, `MEM_LATENCY);
      check_value("instr_rdata", instr_rdata, exp_instr);
      @(posedge clock);
      #1;
      instr_read = 1'b0;
    end
    if (data_read) begin
      wait_pulse(PORT_DREAD, edges);
      if (e.kind != KIND_PAIR) begin
        check_value("data_latency", edges - 1, `MEM_LATENCY);
      end
      check_value("data_rdata", data_rdata, exp_data);
      @(posedge clock);
      #1;
      data_read = 1'b0;
    end
    if (data_write) begin
      wait_pulse(PORT_DWRITE, edges);
      check_value("write_latency", edges - 1, `MEM_LATENCY);
      model_mem[word_index(e.daddr)] = e.wdata;
      @(posedge clock);
      #1;
      data_write = 1'b0;
    end

    // pulses last a single cycle
    @(negedge clock);
    check_pulses_low();
    @(posedge clock);
    #1;
  endtask

  initial begin
    arst_n        = 1'b0;
    instr_read    = 1'b0;
    instr_address = '0;
    data_read     = 1'b0;
    data_write    = 1'b0;
    data_address  = '0;
    data_wdata    = '0;
    error_count   = 0;
    lfsr_state    = 16'd44;
    build_stimulus();

    repeat (RESET_CYCLES) begin
      @(posedge clock);
      @(negedge clock);
      check_pulses_low();
    end
    @(posedge clock);
    #1;
    arst_n = 1'b1;
    @(negedge clock);
    check_pulses_low();
    @(posedge clock);
    #1;

    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end

    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
